//--- hdl/icache_pkg.sv
package icache_pkg;

    // Cache geometry
    localparam int NUM_WAYS       = 4;
    localparam int WAY_W          = 2;
    localparam int NUM_SETS       = 128;
    localparam int INDEX_W        = 7;
    localparam int TAG_W          = 20;
    localparam int OFFSET_W       = 5;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = 256;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [31:0]         addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [WAY_W-1:0]    way_t;
    typedef logic [NUM_WAYS-1:0] way_vec_t;
    typedef logic [3:0]          rnum_t;

    // One-hot controller states
    typedef enum logic [5:0] {
        IDLE    = 6'b000001,
        LOOKUP  = 6'b000010,
        REPLACE = 6'b000100,
        REFILL  = 6'b001000,
        UREQ    = 6'b010000,
        URESP   = 6'b100000
    } state_t;

endpackage

//--- hdl/sync_ram.sv
module sync_ram #(
    parameter type T     = logic,
    parameter int  DEPTH = icache_pkg::NUM_SETS
) (
    input  logic               clk,
    input  logic               en,
    input  logic               we,
    input  icache_pkg::index_t addr,
    input  T                   din,
    output T                   dout
);

    T mem [DEPTH];

    // Read-first, result one cycle after en
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= din;
            end
            dout <= mem[addr];
        end
    end

endmodule

//--- hdl/cache_way.sv
module cache_way (
    input  logic               clk,
    input  logic               resetn,
    input  logic               lookup_en,
    input  icache_pkg::index_t req_index,
    input  icache_pkg::index_t rb_index,
    input  icache_pkg::tag_t   rb_tag,
    input  logic               fill,
    input  icache_pkg::line_t  fill_line,
    output logic               hit,
    output icache_pkg::line_t  line
);

    import icache_pkg::*;

    logic [NUM_SETS-1:0] valid_bits;
    index_t              ram_addr;
    logic                ram_en;
    tag_t                stored_tag;

    // Lookup reads the new index, fill writes the buffered one
    assign ram_addr = fill ? rb_index : req_index;
    assign ram_en   = lookup_en | fill;

    sync_ram #(
        .T     (tag_t),
        .DEPTH (NUM_SETS)
    ) u_tag_ram (
        .clk  (clk),
        .en   (ram_en),
        .we   (fill),
        .addr (ram_addr),
        .din  (rb_tag),
        .dout (stored_tag)
    );

    sync_ram #(
        .T     (line_t),
        .DEPTH (NUM_SETS)
    ) u_line_ram (
        .clk  (clk),
        .en   (ram_en),
        .we   (fill),
        .addr (ram_addr),
        .din  (fill_line),
        .dout (line)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
        end else if (fill) begin
            valid_bits[rb_index] <= 1'b1;
        end
    end

    assign hit = valid_bits[rb_index] & (stored_tag == rb_tag);

endmodule

//--- hdl/plru.sv
module plru (
    input  logic                 clk,
    input  logic                 resetn,
    input  icache_pkg::index_t   index,
    input  icache_pkg::way_vec_t hit_vec,
    input  logic                 lookup_hit,
    input  logic                 capture,
    input  logic                 replace,
    output icache_pkg::way_t     victim
);

    import icache_pkg::*;

    way_vec_t [NUM_SETS-1:0] mru;
    way_vec_t                cur;
    way_vec_t                victim_oh;
    way_t                    first_free;

    // Set the touched way; once every way would be set, only it stays
    function automatic way_vec_t touch(way_vec_t bits, way_vec_t sel);
        way_vec_t nxt;
        nxt = bits | sel;
        if (&nxt) begin
            nxt = sel;
        end
        return nxt;
    endfunction

    assign cur = mru[index];

    always_comb begin
        victim_oh         = '0;
        victim_oh[victim] = 1'b1;
    end

    // Lowest way not recently used
    always_comb begin
        first_free = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!cur[w]) begin
                first_free = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mru    <= '0;
            victim <= '0;
        end else begin
            if (lookup_hit) begin
                mru[index] <= touch(cur, hit_vec);
            end else if (replace) begin
                mru[index] <= touch(cur, victim_oh);
            end
            if (capture) begin
                victim <= first_free;
            end
        end
    end

endmodule

//--- hdl/icache_ctrl.sv
module icache_ctrl (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 valid,
    input  logic                 uncache,
    input  icache_pkg::tag_t     tag,
    input  icache_pkg::index_t   index,
    input  icache_pkg::offset_t  offset,
    output logic                 addr_ok,
    output logic                 data_ok,
    output icache_pkg::line_t    rdata,
    output icache_pkg::rnum_t    rnum,
    output logic                 rd_req,
    output logic                 rd_type,
    output icache_pkg::addr_t    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  icache_pkg::line_t    ret_data,
    input  icache_pkg::way_vec_t hit_vec,
    input  icache_pkg::line_t    way_lines [icache_pkg::NUM_WAYS],
    output logic                 lookup_en,
    output icache_pkg::index_t   rb_index,
    output icache_pkg::tag_t     rb_tag,
    output icache_pkg::way_vec_t fill_way,
    input  icache_pkg::way_t     victim,
    output logic                 lookup_hit,
    output logic                 capture,
    output logic                 replace
);

    import icache_pkg::*;

    state_t  state;
    state_t  next_state;
    offset_t rb_offset;
    logic    cache_hit;
    line_t   hit_line;
    word_t   ret_word;

    assign cache_hit = |hit_vec;
    assign ret_word  = ret_data[WORD_W-1:0];

    assign addr_ok   = valid & ((state == IDLE) | ((state == LOOKUP) & cache_hit));
    assign lookup_en = addr_ok & ~uncache;

    // Request buffer
    always_ff @(posedge clk) begin
        if (addr_ok) begin
            rb_tag    <= tag;
            rb_index  <= index;
            rb_offset <= offset;
        end
    end

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_line = hit_line | way_lines[w];
            end
        end
    end

    assign lookup_hit = (state == LOOKUP) & cache_hit;
    assign capture    = (state == LOOKUP) & ~cache_hit;
    assign replace    = (state == REPLACE);

    always_comb begin
        fill_way = '0;
        if (state == REFILL && ret_valid) begin
            fill_way[victim] = 1'b1;
        end
    end

    // CPU outputs
    assign data_ok = lookup_hit | (((state == REFILL) | (state == URESP)) & ret_valid);

    always_comb begin
        rdata = '0;
        if (lookup_hit) begin
            rdata = hit_line;
        end else if (state == REFILL && ret_valid) begin
            rdata = ret_data;
        end else if (state == URESP && ret_valid) begin
            rdata = {ret_word, {(LINE_W - WORD_W){1'b0}}};
        end
    end

    // Words left in the line from the requested one
    assign rnum = (state == URESP) ? rnum_t'(1) :
                  rnum_t'(WORDS_PER_LINE) - rnum_t'(rb_offset[OFFSET_W-1:2]);

    // Memory outputs
    assign rd_req  = (state == REPLACE) | (state == UREQ);
    assign rd_type = (state != UREQ);
    assign rd_addr = (state == UREQ) ? {rb_tag, rb_index, rb_offset} :
                                       {rb_tag, rb_index, {OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE, LOOKUP: begin
                if (state == LOOKUP && !cache_hit) begin
                    next_state = REPLACE;
                end else if (addr_ok) begin
                    next_state = uncache ? UREQ : LOOKUP;
                end else begin
                    next_state = IDLE;
                end
            end
            REPLACE: if (rd_rdy) next_state = REFILL;
            REFILL:  if (ret_valid) next_state = IDLE;
            UREQ:    if (rd_rdy) next_state = URESP;
            URESP:   if (ret_valid) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

endmodule

//--- hdl/icache_top.sv
module icache_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                valid,
    input  logic                uncache,
    input  icache_pkg::tag_t    tag,
    input  icache_pkg::index_t  index,
    input  icache_pkg::offset_t offset,
    output logic                addr_ok,
    output logic                data_ok,
    output icache_pkg::line_t   rdata,
    output icache_pkg::rnum_t   rnum,
    output logic                rd_req,
    output logic                rd_type,
    output icache_pkg::addr_t   rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  icache_pkg::line_t   ret_data
);

    import icache_pkg::*;

    wire way_vec_t hit_vec;
    wire line_t    way_lines [NUM_WAYS];
    wire           lookup_en;
    wire index_t   rb_index;
    wire tag_t     rb_tag;
    wire way_vec_t fill_way;
    wire way_t     victim;
    wire           lookup_hit;
    wire           capture;
    wire           replace;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
        cache_way u_way (
            .clk       (clk),
            .resetn    (resetn),
            .lookup_en (lookup_en),
            .req_index (index),
            .rb_index  (rb_index),
            .rb_tag    (rb_tag),
            .fill      (fill_way[w]),
            .fill_line (ret_data),
            .hit       (hit_vec[w]),
            .line      (way_lines[w])
        );
    end

    plru u_plru (
        .clk        (clk),
        .resetn     (resetn),
        .index      (rb_index),
        .hit_vec    (hit_vec),
        .lookup_hit (lookup_hit),
        .capture    (capture),
        .replace    (replace),
        .victim     (victim)
    );

    icache_ctrl u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .valid      (valid),
        .uncache    (uncache),
        .tag        (tag),
        .index      (index),
        .offset     (offset),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rnum       (rnum),
        .rd_req     (rd_req),
        .rd_type    (rd_type),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_data   (ret_data),
        .hit_vec    (hit_vec),
        .way_lines  (way_lines),
        .lookup_en  (lookup_en),
        .rb_index   (rb_index),
        .rb_tag     (rb_tag),
        .fill_way   (fill_way),
        .victim     (victim),
        .lookup_hit (lookup_hit),
        .capture    (capture),
        .replace    (replace)
    );

endmodule

//--- dv/icache_checker.sv
module icache_checker (
    input logic                 clk,
    input logic                 resetn,
    input logic                 data_ok,
    input logic                 rd_req,
    input logic                 rd_rdy,
    input icache_pkg::addr_t    rd_addr,
    input logic                 lookup_hit,
    input icache_pkg::way_vec_t hit_vec
);

    int fail_count = 0;

    a_req_data_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && data_ok))
        else begin
            $error("rd_req and data_ok high in the same cycle");
            fail_count++;
        end

    // Memory request held until accepted
    a_req_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else begin
            $error("rd_req dropped or rd_addr changed before rd_rdy");
            fail_count++;
        end

    // A tag lives in at most one way of a set
    a_hit_onehot: assert property (@(posedge clk) disable iff (!resetn)
        lookup_hit |-> $onehot(hit_vec))
        else begin
            $error("more than one way hit in the same lookup");
            fail_count++;
        end

endmodule

bind icache_ctrl icache_checker u_checker (
    .clk        (clk),
    .resetn     (resetn),
    .data_ok    (data_ok),
    .rd_req     (rd_req),
    .rd_rdy     (rd_rdy),
    .rd_addr    (rd_addr),
    .lookup_hit (lookup_hit),
    .hit_vec    (hit_vec)
);

//--- dv/icache_tb.sv
module icache_tb;

    import icache_pkg::*;

    localparam int CYCLES_PER_ENTRY = 40;

    logic    clk;
    logic    resetn;
    logic    valid;
    logic    uncache;
    tag_t    tag;
    index_t  index;
    offset_t offset;
    logic    addr_ok;
    logic    data_ok;
    line_t   rdata;
    rnum_t   rnum;
    logic    rd_req;
    logic    rd_type;
    addr_t   rd_addr;
    logic    rd_rdy;
    logic    ret_valid;
    line_t   ret_data;

    // Trace columns with one element per request
    addr_t tr_addr [$];
    logic  tr_unc [$];
    logic  tr_hit [$];
    word_t tr_word [$];
    int    accepted_at [$];

    int   busy_q [$];
    int   next_idx;
    int   n_done;
    int   cycle;
    int   limit;
    logic miss_seen;
    int   seed;

    icache_top uut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_error(string msg);
        abort_run($sformatf("ERROR at time %0t: %s", $time, msg));
    endtask

    task automatic check_line(line_t got, line_t exp);
        if (got !== exp) begin
            report_error($sformatf("rdata got %h expected %h", got, exp));
        end
    endtask

    task automatic check_word(word_t got, word_t exp);
        if (got !== exp) begin
            report_error($sformatf("requested word got %h expected %h", got, exp));
        end
    endtask

    task automatic check_rnum(rnum_t got, rnum_t exp);
        if (got !== exp) begin
            report_error($sformatf("rnum got %0d expected %0d", got, exp));
        end
    endtask

    task automatic check_addr(addr_t got, addr_t exp);
        if (got !== exp) begin
            report_error($sformatf("rd_addr got %h expected %h", got, exp));
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            report_error($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    task automatic check_cycle(int got, int exp, string what);
        if (got != exp) begin
            report_error($sformatf("%s in cycle %0d expected cycle %0d", what, got, exp));
        end
    endtask

    // Each memory word is its own address XORed with a fixed pattern
    function automatic word_t mem_word(addr_t a);
        return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic line_t mem_line(addr_t line_addr);
        line_t l;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            l[k*WORD_W +: WORD_W] = mem_word(line_addr + addr_t'(4 * k));
        end
        return l;
    endfunction

    task automatic load_trace();
        int          fd;
        string       text;
        logic [31:0] a_in;
        logic [3:0]  u_in;
        logic [3:0]  h_in;
        logic [31:0] w_in;
        fd = $fopen("dv/icache_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file dv/icache_trace.txt");
        end
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() > 1 && text[0] != "#") begin
                if ($sscanf(text, "%h %h %h %h", a_in, u_in, h_in, w_in) != 4) begin
                    abort_run($sformatf("Malformed trace line: %s", text));
                end
                tr_addr.push_back(a_in);
                tr_unc.push_back(u_in[0]);
                tr_hit.push_back(h_in[0]);
                tr_word.push_back(w_in);
            end
        end
        $fclose(fd);
        if (tr_addr.size() == 0) begin
            abort_run("The trace file holds no requests");
        end
    endtask

    task automatic drive_request();
        if (next_idx < tr_addr.size()) begin
            valid                = 1'b1;
            uncache              = tr_unc[next_idx];
            {tag, index, offset} = tr_addr[next_idx];
        end else begin
            valid = 1'b0;
        end
    endtask

    // Called mid-cycle to see what the next rising edge will take
    task automatic sample_cycle();
        int    i;
        addr_t a;
        line_t exp_line;
        word_t got_word;
        if (uut.u_ctrl.u_checker.fail_count != 0) begin
            abort_run("A protocol assertion in the checker failed");
        end
        if (rd_req) begin
            if (busy_q.size() != 1) begin
                abort_run("Memory read request without exactly one pending request");
            end
            i = busy_q[0];
            a = tr_unc[i] ? tr_addr[i] : {tr_addr[i][31:OFFSET_W], {OFFSET_W{1'b0}}};
            miss_seen = 1'b1;
            check_flag(rd_type, !tr_unc[i], "rd_type");
            check_addr(rd_addr, a);
        end
        if (data_ok) begin
            if (busy_q.size() == 0) begin
                abort_run("data_ok arrived with no pending request");
            end
            i = busy_q.pop_front();
            a = tr_addr[i];
            check_flag(!miss_seen, tr_hit[i], "hit");
            if (tr_hit[i]) begin
                check_cycle(cycle, accepted_at[i] + 1, "hit data_ok");
            end
            if (tr_unc[i]) begin
                exp_line = {mem_word(a), {(LINE_W - WORD_W){1'b0}}};
                got_word = rdata[LINE_W-1 -: WORD_W];
                check_rnum(rnum, rnum_t'(1));
            end else begin
                exp_line = mem_line({a[31:OFFSET_W], {OFFSET_W{1'b0}}});
                got_word = rdata[a[OFFSET_W-1:2]*WORD_W +: WORD_W];
                check_rnum(rnum, rnum_t'(WORDS_PER_LINE - a[OFFSET_W-1:2]));
            end
            check_line(rdata, exp_line);
            check_word(got_word, tr_word[i]);
            miss_seen = 1'b0;
            n_done++;
        end
        if (valid && addr_ok) begin
            // A hit frees the cache for the next request in its LOOKUP cycle
            if (next_idx > 0 && tr_hit[next_idx-1]) begin
                check_cycle(cycle, accepted_at[next_idx-1] + 1, "accept after hit");
            end
            busy_q.push_back(next_idx);
            accepted_at.push_back(cycle);
            next_idx++;
        end
    endtask

    // Memory responder
    initial begin : memory_model
        logic  line_req;
        addr_t req_addr;
        int    delay;
        bit    taken;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            taken    = resetn && rd_req && rd_rdy;
            line_req = rd_type;
            req_addr = rd_addr;
            @(posedge clk);
            #1;
            if (taken) begin
                rd_rdy = 1'b0;
                delay  = 1 + ({$random(seed)} % 3);
                for (int k = 1; k < delay; k++) begin
                    @(posedge clk);
                    #1;
                end
                ret_valid = 1'b1;
                ret_data  = line_req ? mem_line(req_addr) : line_t'(mem_word(req_addr));
                @(posedge clk);
                #1;
                ret_valid = 1'b0;
                ret_data  = '0;
            end
            rd_rdy = (({$random(seed)} % 3) == 0);
        end
    end

    initial begin
        seed      = 32'ha4db_98d3;
        resetn    = 1'b0;
        valid     = 1'b0;
        uncache   = 1'b0;
        tag       = '0;
        index     = '0;
        offset    = '0;
        next_idx  = 0;
        n_done    = 0;
        cycle     = 0;
        miss_seen = 1'b0;
        load_trace();
        limit = CYCLES_PER_ENTRY * tr_addr.size();
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;
        drive_request();
        while (n_done < tr_addr.size() && cycle < limit) begin
            @(negedge clk);
            sample_cycle();
            @(posedge clk);
            cycle++;
            #1;
            drive_request();
        end
        if (n_done < tr_addr.size()) begin
            abort_run($sformatf("Run timed out after %0d cycles with %0d of %0d requests done",
                                cycle, n_done, tr_addr.size()));
        end else if (uut.u_ctrl.u_checker.fail_count != 0) begin
            abort_run("A protocol assertion in the checker failed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- icache.f
hdl/icache_pkg.sv
hdl/sync_ram.sv
hdl/cache_way.sv
hdl/plru.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
dv/icache_checker.sv
dv/icache_tb.sv

//--- dv/icache_trace.txt
# addr uncache exp_hit exp_word, all hex
# exp_word is the memory word at addr; exp_hit 0 means memory was read
00000104 0 0 5a5a0104
0000011c 0 1 5a5a011c
00000100 0 1 5a5a0100
00000110 0 1 5a5a0110
00001060 0 0 5a5a1060
00002060 0 0 5a5a2060
00003060 0 0 5a5a3060
00004060 0 0 5a5a4060
0000107c 0 1 5a5a107c
00005060 0 0 5a5a5060
00002068 0 0 5a5a2068
00004070 0 1 5a5a4070
00001060 0 1 5a5a1060
00003064 0 0 5a5a3064
00005078 0 0 5a5a5078
00002060 0 1 5a5a2060
00000208 1 0 5a5a0208
00000208 0 0 5a5a0208
0000020c 0 1 5a5a020c
00000104 1 0 5a5a0104
00000104 0 1 5a5a0104
bfc00ab4 0 0 e59a0ab4
bfc00aa0 0 1 e59a0aa0
